//--- hdl/acq_pkg.sv
package acq_pkg;

	// analog multiplexer channel select
	typedef logic [2:0] channel_t;

	// raw converter result
	typedef logic [7:0] sample_t;

	// one captured sample, channel in the upper bits
	typedef struct packed {
		channel_t channel;
		sample_t  data;
	} sample_rec_t;

	// cycles of mux_en ahead of soc so the analog input can settle
	localparam int SETTLE_CYCLES = 2;

	// settle counter must reach SETTLE_CYCLES - 1
	localparam int SETTLE_W = $clog2(SETTLE_CYCLES + 1);

	typedef logic [SETTLE_W-1:0] settle_cnt_t;

	// acquisition sequencer states
	// idle also serves as the one-cycle gap between samples
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_SETTLE,
		SEQ_CONVERT,
		SEQ_WAIT_END,
		SEQ_CAPTURE,
		SEQ_REQUEST
	} seq_state_t;

endpackage

//--- hdl/link_pkg.sv
package link_pkg;

	// one serial byte
	typedef logic [7:0] byte_t;

	// bit period in clock cycles
	typedef logic [9:0] period_t;

	// configuration write data
	typedef logic [15:0] cfg_word_t;

	// position inside a frame, start bit is 0
	typedef logic [3:0] bit_idx_t;

	// live link configuration
	typedef struct packed {
		period_t           bit_period;
		acq_pkg::channel_t last_channel;
	} link_cfg_t;

	// upper field of a header byte, the channel fills the low bits
	localparam logic [4:0] HEADER_MARK = 5'b10100;

	// reset values, 104 cycles per bit and all eight channels
	localparam period_t           RESET_BIT_PERIOD   = 10'd104;
	localparam acq_pkg::channel_t RESET_LAST_CHANNEL = 3'd7;

	// shortest bit period the serializer accepts
	localparam period_t MIN_BIT_PERIOD = 10'd4;

	// start bit, eight data bits, stop bit
	localparam int       FRAME_BITS    = 10;
	localparam bit_idx_t LAST_DATA_IDX = bit_idx_t'(FRAME_BITS - 2);
	localparam bit_idx_t STOP_IDX      = bit_idx_t'(FRAME_BITS - 1);

	// configuration register map
	localparam logic CFG_ADDR_PERIOD  = 1'b0;
	localparam logic CFG_ADDR_CHANNEL = 1'b1;

endpackage

//--- hdl/link_config.sv
`timescale 1ns/100ps

module link_config (
	input  logic                clock,
	input  logic                reset,
	input  logic                cfg_we,
	input  logic                cfg_addr,
	input  link_pkg::cfg_word_t cfg_wdata,
	output link_pkg::link_cfg_t cfg
);

	import link_pkg::*;

	// candidate bit period from the low bits of the write
	period_t wr_period;

	assign wr_period = cfg_wdata[$bits(period_t)-1:0];

	// write-only registers, new value visible the cycle after cfg_we
	always_ff @(posedge clock) begin
		if (reset) begin
			cfg.bit_period   <= RESET_BIT_PERIOD;
			cfg.last_channel <= RESET_LAST_CHANNEL;
		end else if (cfg_we) begin
			if (cfg_addr == CFG_ADDR_PERIOD) begin
				// a period below the minimum is dropped, old value kept
				if (wr_period >= MIN_BIT_PERIOD) begin
					cfg.bit_period <= wr_period;
				end
			end else if (cfg_addr == CFG_ADDR_CHANNEL) begin
				// channel count wraps after this one
				cfg.last_channel <= cfg_wdata[2:0];
			end
		end
	end

	// the serializer loads this period at every frame start
	// and its bit timer needs at least the minimum
	a_period_min: assert property (@(posedge clock) disable iff (reset)
		cfg.bit_period >= MIN_BIT_PERIOD);

endmodule

//--- hdl/adc_sequencer.sv
`timescale 1ns/100ps

module adc_sequencer (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 eoc,
	input  acq_pkg::sample_t     data_in,
	input  acq_pkg::channel_t    last_channel,
	input  logic                 sample_done,
	output logic                 mux_en,
	output logic                 soc,
	output logic                 load_dato,
	output acq_pkg::channel_t    canale,
	output acq_pkg::sample_rec_t sample,
	output logic                 sample_req
);

	import acq_pkg::*;

	seq_state_t  state;
	settle_cnt_t settle_cnt;
	channel_t    next_channel;

	// wrap also covers a last_channel lowered below the current channel
	assign next_channel = (canale >= last_channel) ? '0 : canale + 1'b1;

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= SEQ_IDLE;
			settle_cnt <= '0;
			mux_en     <= 1'b0;
			soc        <= 1'b0;
			load_dato  <= 1'b0;
			canale     <= '0;
			sample_req <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					// open the multiplexer on the current channel
					mux_en     <= 1'b1;
					settle_cnt <= '0;
					state      <= SEQ_SETTLE;
				end
				SEQ_SETTLE: begin
					settle_cnt <= settle_cnt + 1'b1;
					if (settle_cnt == settle_cnt_t'(SETTLE_CYCLES - 1)) begin
						soc   <= 1'b1;
						state <= SEQ_CONVERT;
					end
				end
				SEQ_CONVERT: begin
					// soc is a single cycle strobe
					soc <= 1'b0;
					if (eoc) begin
						state <= SEQ_WAIT_END;
					end
				end
				SEQ_WAIT_END: begin
					// falling eoc means the result is ready
					if (!eoc) begin
						load_dato <= 1'b1;
						mux_en    <= 1'b0;
						state     <= SEQ_CAPTURE;
					end
				end
				SEQ_CAPTURE: begin
					load_dato  <= 1'b0;
					canale     <= next_channel;
					sample_req <= 1'b1;
					state      <= SEQ_REQUEST;
				end
				SEQ_REQUEST: begin
					// hold the record until the scheduler has sent both bytes
					if (sample_done) begin
						sample_req <= 1'b0;
						state      <= SEQ_IDLE;
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	// sample record, taken while load_dato is high
	// channel is the one that was converted, before the step
	always_ff @(posedge clock) begin
		if (state == SEQ_CAPTURE) begin
			sample.channel <= canale;
			sample.data    <= data_in;
		end
	end

	// capture closes a conversion window that mux_en held open
	a_load_after_mux: assert property (@(posedge clock) disable iff (reset)
		load_dato |-> !mux_en && $past(mux_en));

	// a stable last_channel from the config block bounds the stepped channel
	a_channel_range: assert property (@(posedge clock) disable iff (reset)
		$rose(sample_req) && $stable(last_channel) |-> canale <= last_channel);

endmodule

//--- hdl/frame_scheduler.sv
`timescale 1ns/100ps

module frame_scheduler (
	input  logic                 clock,
	input  logic                 reset,
	input  acq_pkg::sample_rec_t sample,
	input  logic                 sample_req,
	input  logic                 confirm,
	output logic                 sample_done,
	output link_pkg::byte_t      tx_byte,
	output logic                 shot,
	output logic                 add_mpx2
);

	import link_pkg::*;

	// header byte in flight, then data byte in flight
	typedef enum logic [1:0] {
		FS_IDLE,
		FS_HEADER,
		FS_DATA
	} fs_state_t;

	fs_state_t state;

	// second confirm finishes the sample
	assign sample_done = (state == FS_DATA) && confirm;

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= FS_IDLE;
			shot     <= 1'b0;
			add_mpx2 <= 1'b0;
		end else begin
			shot <= 1'b0;
			case (state)
				FS_IDLE: begin
					if (sample_req) begin
						shot  <= 1'b1;
						state <= FS_HEADER;
					end
				end
				FS_HEADER: begin
					// data byte follows right after the header is done
					if (confirm) begin
						shot     <= 1'b1;
						add_mpx2 <= 1'b1;
						state    <= FS_DATA;
					end
				end
				FS_DATA: begin
					if (confirm) begin
						add_mpx2 <= 1'b0;
						state    <= FS_IDLE;
					end
				end
				default: begin
					state <= FS_IDLE;
				end
			endcase
		end
	end

	// byte to send, set up together with each shot
	always_ff @(posedge clock) begin
		if (state == FS_IDLE && sample_req) begin
			tx_byte <= {HEADER_MARK, sample.channel};
		end else if (state == FS_HEADER && confirm) begin
			tx_byte <= sample.data;
		end
	end

endmodule

//--- hdl/tx_holding.sv
`timescale 1ns/100ps

module tx_holding (
	input  logic            clock,
	input  logic            reset,
	input  link_pkg::byte_t tx_byte,
	input  logic            shot,
	input  logic            dsr,
	input  logic            tx_end,
	output logic            confirm,
	output link_pkg::byte_t ser_byte,
	output logic            ser_start,
	output logic            error
);

	import link_pkg::*;

	typedef enum logic [1:0] {
		TH_IDLE,
		TH_LOAD,
		TH_CHECK,
		TH_WAIT_END
	} th_state_t;

	th_state_t state;
	byte_t     hold_reg;
	// holding register owns a byte
	logic      full;

	// serializer latches the byte at ser_start
	assign ser_byte = hold_reg;

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= TH_IDLE;
			full      <= 1'b0;
			confirm   <= 1'b0;
			ser_start <= 1'b0;
			error     <= 1'b0;
		end else begin
			confirm   <= 1'b0;
			ser_start <= 1'b0;
			case (state)
				TH_IDLE: begin
					if (shot) begin
						state <= TH_LOAD;
					end
				end
				TH_LOAD: begin
					full  <= 1'b1;
					state <= TH_CHECK;
				end
				TH_CHECK: begin
					if (dsr) begin
						// receiver ready, hand off to the serializer
						ser_start <= 1'b1;
						error     <= 1'b0;
						state     <= TH_WAIT_END;
					end else begin
						// no data set ready, byte is lost
						error   <= 1'b1;
						full    <= 1'b0;
						confirm <= 1'b1;
						state   <= TH_IDLE;
					end
				end
				TH_WAIT_END: begin
					if (tx_end) begin
						full    <= 1'b0;
						confirm <= 1'b1;
						state   <= TH_IDLE;
					end
				end
				default: begin
					state <= TH_IDLE;
				end
			endcase
			// overrun, a new byte while one is still held
			if (shot && full) begin
				error <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == TH_LOAD) begin
			hold_reg <= tx_byte;
		end
	end

	// scheduler waits for confirm, so a shot never finds the register full
	a_no_overrun: assert property (@(posedge clock) disable iff (reset)
		shot |-> !full);

	// error only rises from an overrun or a dsr fault at the check
	a_error_cause: assert property (@(posedge clock) disable iff (reset)
		$rose(error) |-> $past(shot && full) || $past(state == TH_CHECK && !dsr));

endmodule

//--- hdl/uart_serializer.sv
`timescale 1ns/100ps

module uart_serializer (
	input  logic              clock,
	input  logic              reset,
	input  link_pkg::byte_t   ser_byte,
	input  logic              ser_start,
	input  link_pkg::period_t bit_period,
	output logic              data_out,
	output logic              tx_end
);

	import link_pkg::*;

	logic     busy;
	// bit currently on the line
	bit_idx_t bit_idx;
	// cycles left in the current bit
	period_t  timer;
	// period held for the whole frame
	period_t  period_q;
	byte_t    shift_reg;
	logic     bit_done;

	assign bit_done = busy && (timer == '0);

	// last cycle of the stop bit
	assign tx_end = bit_done && (bit_idx == STOP_IDX);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy     <= 1'b0;
			bit_idx  <= '0;
			timer    <= '0;
			data_out <= 1'b1;
		end else if (ser_start && !busy) begin
			// start bit goes out at once
			busy     <= 1'b1;
			bit_idx  <= '0;
			timer    <= bit_period - 1'b1;
			data_out <= 1'b0;
		end else if (bit_done) begin
			if (bit_idx == STOP_IDX) begin
				busy     <= 1'b0;
				data_out <= 1'b1;
			end else begin
				bit_idx  <= bit_idx + 1'b1;
				timer    <= period_q - 1'b1;
				// after the last data bit comes the stop bit
				data_out <= (bit_idx == LAST_DATA_IDX) ? 1'b1 : shift_reg[7];
			end
		end else if (busy) begin
			timer <= timer - 1'b1;
		end
	end

	// MSB first, shift left as each data bit is put on the line
	always_ff @(posedge clock) begin
		if (ser_start && !busy) begin
			period_q  <= bit_period;
			shift_reg <= ser_byte;
		end else if (bit_done && bit_idx < LAST_DATA_IDX) begin
			shift_reg <= {shift_reg[6:0], 1'b0};
		end
	end

	// holding stage waits for tx_end before the next start
	a_start_idle: assert property (@(posedge clock) disable iff (reset)
		ser_start |-> !busy);

endmodule

//--- hdl/acq_link_top.sv
`timescale 1ns/100ps

module acq_link_top (
	input  logic                clock,
	input  logic                reset,
	// converter side
	output logic                mux_en,
	output acq_pkg::channel_t   canale,
	output logic                soc,
	input  logic                eoc,
	input  acq_pkg::sample_t    data_in,
	output logic                load_dato,
	// link side
	output logic                add_mpx2,
	input  logic                dsr,
	output logic                error,
	output logic                data_out,
	// configuration side
	input  logic                cfg_we,
	input  logic                cfg_addr,
	input  link_pkg::cfg_word_t cfg_wdata
);

	import acq_pkg::*;
	import link_pkg::*;

	link_cfg_t   cfg;
	// sequencer to scheduler
	sample_rec_t sample;
	logic        sample_req;
	logic        sample_done;
	// scheduler to holding stage
	byte_t       tx_byte;
	logic        shot;
	logic        confirm;
	// holding stage to serializer
	byte_t       ser_byte;
	logic        ser_start;
	logic        tx_end;

	link_config i_link_config (
		.clock     (clock),
		.reset     (reset),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg       (cfg)
	);

	adc_sequencer i_adc_sequencer (
		.clock        (clock),
		.reset        (reset),
		.eoc          (eoc),
		.data_in      (data_in),
		.last_channel (cfg.last_channel),
		.sample_done  (sample_done),
		.mux_en       (mux_en),
		.soc          (soc),
		.load_dato    (load_dato),
		.canale       (canale),
		.sample       (sample),
		.sample_req   (sample_req)
	);

	frame_scheduler i_frame_scheduler (
		.clock       (clock),
		.reset       (reset),
		.sample      (sample),
		.sample_req  (sample_req),
		.confirm     (confirm),
		.sample_done (sample_done),
		.tx_byte     (tx_byte),
		.shot        (shot),
		.add_mpx2    (add_mpx2)
	);

	tx_holding i_tx_holding (
		.clock     (clock),
		.reset     (reset),
		.tx_byte   (tx_byte),
		.shot      (shot),
		.dsr       (dsr),
		.tx_end    (tx_end),
		.confirm   (confirm),
		.ser_byte  (ser_byte),
		.ser_start (ser_start),
		.error     (error)
	);

	uart_serializer i_uart_serializer (
		.clock      (clock),
		.reset      (reset),
		.ser_byte   (ser_byte),
		.ser_start  (ser_start),
		.bit_period (cfg.bit_period),
		.data_out   (data_out),
		.tx_end     (tx_end)
	);

endmodule

//--- dv/acq_link_tb.sv
`timescale 1ns/100ps

module acq_link_tb;

	import acq_pkg::*;
	import link_pkg::*;

	localparam logic [31:0] SEED = 32'hea676cca;

	// samples per phase
	localparam int N_BASIC  = 20;
	localparam int N_FAST_A = 8;
	localparam int N_FAST_B = 6;

	// slow samples run at 104 cycles per bit, fast ones at 16
	localparam int SLOW_SAMPLES = N_BASIC + 4;
	localparam int FAST_SAMPLES = N_FAST_A + N_FAST_B + 4;
	// two frames of 10 bits per sample, plus conversion and handshake slack
	localparam int MAX_CYCLES = SLOW_SAMPLES * 2 * 10 * 104
		+ FAST_SAMPLES * 2 * 10 * 16
		+ (SLOW_SAMPLES + FAST_SAMPLES) * 40 + 1000;

	logic      clock;
	logic      reset;
	logic      mux_en;
	channel_t  canale;
	logic      soc;
	logic      eoc;
	sample_t   data_in;
	logic      load_dato;
	logic      add_mpx2;
	logic      dsr;
	logic      error;
	logic      data_out;
	logic      cfg_we;
	logic      logic_cfg_addr;
	cfg_word_t cfg_wdata;

	// expected bytes, top bit marks a data byte
	logic [8:0] exp_q[$];
	channel_t   exp_ch;
	channel_t   tb_last;
	period_t    tb_period;
	logic       drop_sample;
	logic       conv_hold;
	logic       conv_parked;
	logic       line_prev;
	// cycles mux_en has been high so far
	int         mux_cycles;
	logic       mux_prev;
	int         errors;
	int         kind_errors[3];
	int         tests_failed;
	int         frame_count;
	int         pushed_count;
	int         cycle_count;

	acq_link_top i_dut (
		.clock     (clock),
		.reset     (reset),
		.mux_en    (mux_en),
		.canale    (canale),
		.soc       (soc),
		.eoc       (eoc),
		.data_in   (data_in),
		.load_dato (load_dato),
		.add_mpx2  (add_mpx2),
		.dsr       (dsr),
		.error     (error),
		.data_out  (data_out),
		.cfg_we    (cfg_we),
		.cfg_addr  (logic_cfg_addr),
		.cfg_wdata (cfg_wdata)
	);

	always #50 clock = ~clock;

	// kind 0 general, 1 channel order, 2 serial frames
	task automatic report_error(input int kind, input string msg);
		$display("ERROR %0t ns: %s", $time, msg);
		errors++;
		kind_errors[kind]++;
	endtask

	task automatic print_result(input int num, input string name, input int fails);
		if (fails == 0) begin
			$display("test %0d %s: pass", num, name);
		end else begin
			$display("test %0d %s: FAIL, %0d bad checks", num, name, fails);
			tests_failed++;
		end
	endtask

	task automatic wait_load();
		do @(negedge clock); while (!load_dato);
	endtask

	task automatic wait_samples(input int n);
		repeat (n) wait_load();
	endtask

	task automatic wait_mux_rise();
		do @(negedge clock); while (!mux_en);
	endtask

	// queue empties once the data frame of a sample is decoded
	task automatic wait_drain();
		do @(negedge clock); while (exp_q.size() != 0);
	endtask

	task automatic check_idle_outputs();
		if (soc !== 1'b0 || load_dato !== 1'b0 || add_mpx2 !== 1'b0 || error !== 1'b0) begin
			report_error(0, $sformatf("after reset soc %b load_dato %b add_mpx2 %b error %b",
				soc, load_dato, add_mpx2, error));
		end
		if (canale !== '0) begin
			report_error(0, $sformatf("after reset canale %0d, expected 0", canale));
		end
		if (data_out !== 1'b1) begin
			report_error(0, "after reset data_out is 0, expected idle 1");
		end
	endtask

	// register model, periods under 4 are refused
	task automatic write_cfg(input logic addr, input cfg_word_t value);
		@(posedge clock);
		#1;
		cfg_we         = 1'b1;
		logic_cfg_addr = addr;
		cfg_wdata      = value;
		@(posedge clock);
		#1;
		cfg_we = 1'b0;
		if (addr == 1'b0) begin
			if (value[9:0] >= 10'd4) begin
				tb_period = value[9:0];
			end
		end else begin
			tb_last = value[2:0];
		end
	endtask

	// converter, eoc pulse of random length after each soc
	always begin : converter_model
		int unsigned delay;
		@(negedge clock);
		if (soc && conv_hold) begin
			conv_parked = 1'b1;
		end else if (soc) begin
			delay = $urandom_range(6, 1);
			repeat (delay) @(posedge clock);
			#1;
			eoc   = 1'b1;
			delay = $urandom_range(10, 1);
			repeat (delay) @(posedge clock);
			#1;
			// result valid from the falling eoc on
			eoc     = 1'b0;
			data_in = sample_t'($urandom);
		end
	end

	// reference model, header then data byte for every capture
	always @(negedge clock) begin
		if (!reset && load_dato) begin
			if (canale !== exp_ch) begin
				report_error(1, $sformatf("canale %0d at load_dato, expected %0d", canale, exp_ch));
			end
			if (drop_sample) begin
				drop_sample = 1'b0;
			end else begin
				exp_q.push_back({1'b0, HEADER_MARK, exp_ch});
				exp_q.push_back({1'b1, data_in});
				pushed_count += 2;
			end
			exp_ch = (exp_ch >= tb_last) ? '0 : exp_ch + 1'b1;
		end
	end

	// mux_en leads soc by the settle time and falls only with load_dato
	always @(negedge clock) begin
		if (!reset && soc && mux_cycles != SETTLE_CYCLES) begin
			report_error(1, $sformatf("soc after %0d cycles of mux_en, expected %0d",
				mux_cycles, SETTLE_CYCLES));
		end
		if (!reset && mux_prev && !mux_en && !load_dato) begin
			report_error(1, "mux_en fell without load_dato, expected it to fall with load_dato");
		end
		mux_cycles = mux_en ? mux_cycles + 1 : 0;
		mux_prev   = mux_en;
	end

	// serial decoder, every cycle of a bit must match its mid-bit sample
	always begin : serial_decoder
		int         period;
		int         b;
		int         c;
		logic [8:0] entry;
		logic       have_entry;
		logic       first;
		logic       mid;
		logic       unstable;
		logic       mpx_bad;
		logic       start_bit;
		logic       stop_bit;
		byte_t      rx_byte;
		@(negedge clock);
		if (!reset && line_prev && !data_out) begin
			period     = int'(tb_period);
			have_entry = (exp_q.size() > 0);
			entry      = have_entry ? exp_q[0] : '0;
			unstable   = 1'b0;
			mpx_bad    = 1'b0;
			rx_byte    = '0;
			first      = 1'b0;
			mid        = 1'b0;
			start_bit  = 1'b1;
			stop_bit   = 1'b0;
			for (b = 0; b < 10; b++) begin
				for (c = 0; c < period; c++) begin
					// first cycle of the start bit is already sampled
					if (b != 0 || c != 0) begin
						@(negedge clock);
					end
					if (c == 0) first = data_out;
					if (c == period / 2) mid = data_out;
					if (data_out !== first) unstable = 1'b1;
					if (add_mpx2 !== entry[8]) mpx_bad = 1'b1;
				end
				if (b == 0) begin
					start_bit = mid;
				end else if (b == 9) begin
					stop_bit = mid;
				end else begin
					rx_byte = {rx_byte[6:0], mid};
				end
			end
			frame_count++;
			if (start_bit !== 1'b0) report_error(2, "frame start bit is 1, expected 0");
			if (stop_bit !== 1'b1) report_error(2, "frame stop bit is 0, expected 1");
			if (unstable) begin
				report_error(2, $sformatf("data_out changed inside a bit of %0d cycles", period));
			end
			if (mpx_bad) begin
				report_error(2, $sformatf("add_mpx2 not %b during frame", entry[8]));
			end
			if (!have_entry) begin
				report_error(2, $sformatf("frame with byte %h while no byte was expected", rx_byte));
			end else begin
				entry = exp_q.pop_front();
				if (rx_byte !== entry[7:0]) begin
					report_error(2, $sformatf("decoded byte %h, expected %h", rx_byte, entry[7:0]));
				end
			end
		end
		line_prev = data_out;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles, the DUT never finished the tests", cycle_count);
			$display("Errors found");
			$finish;
		end
	end

	initial begin : main
		int base;
		int base_frame;
		clock          = 1'b0;
		reset          = 1'b1;
		eoc            = 1'b0;
		data_in        = '0;
		dsr            = 1'b1;
		cfg_we         = 1'b0;
		logic_cfg_addr = 1'b0;
		cfg_wdata      = '0;
		exp_ch         = '0;
		tb_last        = RESET_LAST_CHANNEL;
		tb_period      = RESET_BIT_PERIOD;
		drop_sample    = 1'b0;
		conv_hold      = 1'b0;
		conv_parked    = 1'b0;
		line_prev      = 1'b1;
		mux_cycles     = 0;
		mux_prev       = 1'b0;
		errors         = 0;
		kind_errors    = '{0, 0, 0};
		tests_failed   = 0;
		frame_count    = 0;
		pushed_count   = 0;
		cycle_count    = 0;
		void'($urandom(SEED));
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		// outputs hold their reset values until the sequencer starts
		base = errors;
		@(negedge clock);
		while (!mux_en) begin
			check_idle_outputs();
			@(negedge clock);
		end
		print_result(1, "reset values", errors - base);

		// default link, all eight channels at 104 cycles per bit
		base       = kind_errors[1];
		base_frame = kind_errors[2];
		wait_samples(N_BASIC);
		wait_drain();
		print_result(2, "channel order", kind_errors[1] - base);
		print_result(3, "frame contents", kind_errors[2] - base_frame);

		// receiver not ready for one whole sample
		base        = errors;
		drop_sample = 1'b1;
		wait_load();
		@(posedge clock);
		#1;
		dsr = 1'b0;
		do begin
			@(negedge clock);
			if (data_out !== 1'b1) begin
				report_error(0, "data_out left idle while dsr was low");
			end
		end while (!mux_en);
		if (error !== 1'b1) report_error(0, "error is 0 after a dsr fault, expected 1");
		@(posedge clock);
		#1;
		dsr = 1'b1;
		wait_load();
		wait_mux_rise();
		if (error !== 1'b0) report_error(0, "error is 1 after a good byte, expected 0");
		wait_drain();
		print_result(4, "dsr fault", errors - base);

		// faster link on four channels, then a period that must be refused
		base = errors;
		wait_load();
		write_cfg(1'b0, 16'd16);
		write_cfg(1'b1, 16'd3);
		wait_samples(N_FAST_A);
		wait_load();
		write_cfg(1'b0, 16'd2);
		wait_samples(N_FAST_B);
		conv_hold = 1'b1;
		do @(negedge clock); while (!(conv_parked && exp_q.size() == 0));
		print_result(5, "configuration", errors - base);

		if (frame_count != pushed_count) begin
			report_error(0, $sformatf("%0d frames decoded, %0d expected", frame_count, pushed_count));
		end
		$display("tests run 5, tests failed %0d, frames %0d, bad checks %0d",
			tests_failed, frame_count, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- all.f
hdl/acq_pkg.sv
hdl/link_pkg.sv
hdl/link_config.sv
hdl/adc_sequencer.sv
hdl/frame_scheduler.sv
hdl/tx_holding.sv
hdl/uart_serializer.sv
hdl/acq_link_top.sv
dv/acq_link_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module acq_link_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vacq_link_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1
